//--- hdl/exu_pkg.sv
// execute unit package: data and pc widths, operation codes, shifter constants
package exu_pkg;

   // data path
   localparam int xlen     = 32;
   localparam int pc_msb   = 31;
   // branch offset is carried as bits brimm_w down to 1
   localparam int brimm_w  = 12;

   // shifter
   localparam int shamt_w  = 5;
   // double-width extension, top bit never needed
   localparam int sh_ext_w = 2 * xlen - 1;

   // 2-bit branch history counter
   localparam int hist_w   = 2;

   // operation code
   localparam int op_w     = 5;

   // arithmetic and logical
   localparam logic [op_w-1:0] op_add  = 5'd0;
   localparam logic [op_w-1:0] op_sub  = 5'd1;
   localparam logic [op_w-1:0] op_and  = 5'd2;
   localparam logic [op_w-1:0] op_or   = 5'd3;
   localparam logic [op_w-1:0] op_xor  = 5'd4;

   // shifts
   localparam logic [op_w-1:0] op_sll  = 5'd5;
   localparam logic [op_w-1:0] op_srl  = 5'd6;
   localparam logic [op_w-1:0] op_sra  = 5'd7;

   // set-less-than
   localparam logic [op_w-1:0] op_slt  = 5'd8;
   localparam logic [op_w-1:0] op_sltu = 5'd9;

   // conditional branches
   localparam logic [op_w-1:0] op_beq  = 5'd10;
   localparam logic [op_w-1:0] op_bne  = 5'd11;
   localparam logic [op_w-1:0] op_blt  = 5'd12;
   localparam logic [op_w-1:0] op_bge  = 5'd13;
   localparam logic [op_w-1:0] op_bltu = 5'd14;
   localparam logic [op_w-1:0] op_bgeu = 5'd15;

   // jumps and upper immediate
   localparam logic [op_w-1:0] op_jal  = 5'd16;
   // lui arrives as an or with a zero first operand
   localparam logic [op_w-1:0] op_lui  = 5'd17;

endpackage

//--- hdl/adder_if.sv
// adder_if: main adder and branch-offset adder results
`timescale 1ns/100ps

interface adder_if;

   logic [exu_pkg::xlen-1:0] sum;
   logic                     eq;
   logic                     lt;
   logic [exu_pkg::pc_msb:1] link_pc;

   modport adders (output sum, output eq, output lt, output link_pc);

   modport result (input sum, input lt, input link_pc);

   modport branch (input sum, input eq, input lt, input link_pc);

endinterface

//--- hdl/exu_adders.sv
// exu_adders: add/subtract with signed and unsigned compare, branch-offset adder
`timescale 1ns/100ps

module exu_adders
(
   input  logic [exu_pkg::xlen-1:0]    a_in,
   input  logic [exu_pkg::xlen-1:0]    b_in,
   input  logic [exu_pkg::op_w-1:0]    op,
   input  logic [exu_pkg::pc_msb:1]    pc_in,
   input  logic [exu_pkg::brimm_w:1]   brimm_in,
   adder_if.adders                     adr
);

   logic                     sub;
   logic                     unsign;
   logic [exu_pkg::xlen-1:0] bm;
   logic [exu_pkg::xlen-1:0] aout;
   logic                     cout;
   logic                     ov;
   logic                     neg;

   // compares and all conditional branches go through the subtractor
   assign sub    = (op == exu_pkg::op_sub)  | (op == exu_pkg::op_slt)  |
                   (op == exu_pkg::op_sltu) | (op == exu_pkg::op_beq)  |
                   (op == exu_pkg::op_bne)  | (op == exu_pkg::op_blt)  |
                   (op == exu_pkg::op_bge)  | (op == exu_pkg::op_bltu) |
                   (op == exu_pkg::op_bgeu);

   assign unsign = (op == exu_pkg::op_sltu) | (op == exu_pkg::op_bltu) |
                   (op == exu_pkg::op_bgeu);

   // a - b as a + ~b + 1
   assign bm = sub ? ~b_in : b_in;

   assign {cout, aout} = {1'b0, a_in} + {1'b0, bm} + {{exu_pkg::xlen{1'b0}}, sub};

   assign neg = aout[exu_pkg::xlen-1];
   assign ov  = (~a_in[exu_pkg::xlen-1] & ~bm[exu_pkg::xlen-1] &  neg) |
                ( a_in[exu_pkg::xlen-1] &  bm[exu_pkg::xlen-1] & ~neg);

   assign adr.sum = aout;
   // unsigned borrow shows as a missing carry out
   assign adr.lt  = (~unsign & (neg ^ ov)) | (unsign & ~cout);
   assign adr.eq  = (a_in == b_in);

   // pc plus sign-extended offset
   // link address for jumps, the not-predicted path for branches
   assign adr.link_pc = pc_in +
                        {{(exu_pkg::pc_msb-exu_pkg::brimm_w){brimm_in[exu_pkg::brimm_w]}},
                         brimm_in};

endmodule

//--- hdl/exu_shifter.sv
// sll, srl and sra through a double-width extend and mask
`timescale 1ns/100ps

module exu_shifter
(
   input  logic [exu_pkg::xlen-1:0]    a_in,
   input  logic [exu_pkg::shamt_w-1:0] shamt,
   input  logic [exu_pkg::op_w-1:0]    op,
   output logic [exu_pkg::xlen-1:0]    sout
);

   logic                         sel_sll;
   logic                         sel_sra;
   logic                         sel_shift;
   logic [exu_pkg::shamt_w-1:0]  shift_amount;
   logic [exu_pkg::xlen-1:0]     shift_mask;
   logic [exu_pkg::sh_ext_w-1:0] shift_extend;
   logic [exu_pkg::sh_ext_w-1:0] shift_long;

   assign sel_sll   = (op == exu_pkg::op_sll);
   assign sel_sra   = (op == exu_pkg::op_sra);
   assign sel_shift = sel_sll | sel_sra | (op == exu_pkg::op_srl);

   // left shift is a right shift by xlen minus amount modulo xlen
   assign shift_amount = sel_sll ? (~shamt + 1'b1) : shamt;

   // upper half takes sign fill for sra, low bits of a for sll and zero for srl
   always_comb
   begin
      if (sel_sra)
      begin
         shift_extend = {{(exu_pkg::xlen-1){a_in[exu_pkg::xlen-1]}}, a_in};
      end
      else if (sel_sll)
      begin
         shift_extend = {a_in[exu_pkg::xlen-2:0], a_in};
      end
      else
      begin
         shift_extend = {{(exu_pkg::xlen-1){1'b0}}, a_in};
      end
   end

   assign shift_long = shift_extend >> shift_amount;

   // clears the wrapped-in low bits for sll
   assign shift_mask = {exu_pkg::xlen{1'b1}} << ({exu_pkg::shamt_w{sel_sll}} & shamt);

   assign sout = {exu_pkg::xlen{sel_shift}} & shift_long[exu_pkg::xlen-1:0] & shift_mask;

endmodule

//--- hdl/exu_branch.sv
// exu_branch: branch resolution, mispredict and flush generation, history update
`timescale 1ns/100ps

module exu_branch
(
   input  logic                        valid_in,
   input  logic                        flush_upper_x,
   input  logic                        flush_lower_r,
   input  logic [exu_pkg::op_w-1:0]    op,
   input  logic                        predict_t,
   input  logic                        predict_nt,
   input  logic                        pcall,
   input  logic                        pja,
   input  logic                        pret,
   input  logic [exu_pkg::pc_msb:1]    prett,
   input  logic [exu_pkg::hist_w-1:0]  hist_in,
   adder_if.branch                     adr,
   output logic                        link_sel,
   output logic                        flush_upper_out,
   output logic                        flush_final_out,
   output logic [exu_pkg::pc_msb:1]    flush_path_out,
   output logic                        pred_correct_out,
   output logic                        misp_out,
   output logic                        ataken_out,
   output logic [exu_pkg::hist_w-1:0]  hist_out
);

   logic is_jal;
   logic any_jal;
   logic actual_taken;
   logic cond_mispredict;
   logic target_mispredict;
   logic flush_req;

   assign is_jal  = (op == exu_pkg::op_jal);
   assign any_jal = is_jal | pcall | pja | pret;

   // jumps write the link address
   assign link_sel = any_jal;

   assign actual_taken = ((op == exu_pkg::op_beq)  &  adr.eq) |
                         ((op == exu_pkg::op_bne)  & ~adr.eq) |
                         ((op == exu_pkg::op_blt)  &  adr.lt) |
                         ((op == exu_pkg::op_bltu) &  adr.lt) |
                         ((op == exu_pkg::op_bge)  & ~adr.lt) |
                         ((op == exu_pkg::op_bgeu) & ~adr.lt) |
                         any_jal;

   // tells the npc logic the flush path is not needed; never for jumps
   assign pred_correct_out = valid_in & ~any_jal &
                             ((predict_nt & ~actual_taken) | (predict_t & actual_taken));

   // jump target is the adder sum, branches go to the other path
   assign flush_path_out = any_jal ? adr.sum[exu_pkg::pc_msb:1] : adr.link_pc;

   assign cond_mispredict   = (predict_t & ~actual_taken) | (predict_nt & actual_taken);
   assign target_mispredict = pret & (prett != adr.sum[exu_pkg::pc_msb:1]);

   assign flush_req = (is_jal | cond_mispredict | target_mispredict) & valid_in & ~flush_upper_x;

   assign flush_upper_out = flush_req & ~flush_lower_r;
   assign flush_final_out = flush_req | flush_lower_r;

   assign misp_out   = ~flush_upper_x & ~flush_lower_r & (cond_mispredict | target_mispredict);
   assign ataken_out = actual_taken;

   // taken: 00->10 01->00 10->11 11->11
   // not taken: 00->01 01->01 10->00 11->10
   assign hist_out[1] = (hist_in[1] & hist_in[0]) | (~hist_in[0] & actual_taken);
   assign hist_out[0] = (~hist_in[1] & ~actual_taken) | (hist_in[1] & actual_taken);

endmodule

//--- hdl/exu_result.sv
// exu_result: logical ops, set-less-than, result select, result and pc registers
`timescale 1ns/100ps

module exu_result
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        enable,
   input  logic                        valid_in,
   input  logic [exu_pkg::op_w-1:0]    op,
   input  logic [exu_pkg::xlen-1:0]    a_in,
   input  logic [exu_pkg::xlen-1:0]    b_in,
   input  logic [exu_pkg::pc_msb:1]    pc_in,
   input  logic [exu_pkg::xlen-1:0]    sout,
   input  logic                        link_sel,
   adder_if.result                     adr,
   output logic [exu_pkg::xlen-1:0]    result_ff,
   output logic [exu_pkg::pc_msb:1]    pc_ff
);

   logic                     sel_and;
   logic                     sel_or;
   logic                     sel_xor;
   logic                     sel_adder;
   logic                     slt_one;
   logic [exu_pkg::xlen-1:0] lout;
   logic [exu_pkg::xlen-1:0] result;

   assign sel_and   = (op == exu_pkg::op_and);
   // lui comes in with a zero a_in, so the or passes the immediate
   assign sel_or    = (op == exu_pkg::op_or) | (op == exu_pkg::op_lui);
   assign sel_xor   = (op == exu_pkg::op_xor);
   assign sel_adder = (op == exu_pkg::op_add) | (op == exu_pkg::op_sub);

   assign slt_one = ((op == exu_pkg::op_slt) | (op == exu_pkg::op_sltu)) & adr.lt;

   assign lout = ({exu_pkg::xlen{sel_and}} & (a_in & b_in)) |
                 ({exu_pkg::xlen{sel_or}}  & (a_in | b_in)) |
                 ({exu_pkg::xlen{sel_xor}} & (a_in ^ b_in));

   // only one source is non-zero for any op
   assign result = lout | sout |
                   ({exu_pkg::xlen{sel_adder}} & adr.sum) |
                   ({exu_pkg::xlen{link_sel}}  & {adr.link_pc, 1'b0}) |
                   {{(exu_pkg::xlen-1){1'b0}}, slt_one};

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         result_ff <= '0;
      end
      else if (enable & valid_in)
      begin
         result_ff <= result;
      end
   end

   // any pc passes through here, valid or not
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pc_ff <= '0;
      end
      else if (enable)
      begin
         pc_ff <= pc_in;
      end
   end

endmodule

//--- hdl/exu_alu.sv
// exu_alu: integer execute unit top, adders, shifter, result path and branch unit
`timescale 1ns/100ps

module exu_alu
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        enable,
   input  logic                        valid_in,
   input  logic                        flush_upper_x,
   input  logic                        flush_lower_r,
   input  logic [exu_pkg::op_w-1:0]    op,
   input  logic [exu_pkg::xlen-1:0]    a_in,
   input  logic [exu_pkg::xlen-1:0]    b_in,
   input  logic [exu_pkg::pc_msb:1]    pc_in,
   input  logic [exu_pkg::brimm_w:1]   brimm_in,
   input  logic                        predict_t,
   input  logic                        predict_nt,
   input  logic                        pcall,
   input  logic                        pja,
   input  logic                        pret,
   input  logic [exu_pkg::pc_msb:1]    prett,
   input  logic [exu_pkg::hist_w-1:0]  hist_in,
   output logic [exu_pkg::xlen-1:0]    result_ff,
   output logic [exu_pkg::pc_msb:1]    pc_ff,
   output logic                        flush_upper_out,
   output logic                        flush_final_out,
   output logic [exu_pkg::pc_msb:1]    flush_path_out,
   output logic                        pred_correct_out,
   output logic                        misp_out,
   output logic                        ataken_out,
   output logic [exu_pkg::hist_w-1:0]  hist_out
);

   logic [exu_pkg::xlen-1:0] sout;
   logic                     link_sel;

   adder_if i_adr ();

   exu_adders i_adders (
      .a_in     (a_in),
      .b_in     (b_in),
      .op       (op),
      .pc_in    (pc_in),
      .brimm_in (brimm_in),
      .adr      (i_adr.adders)
   );

   // shift amount is the low bits of b
   exu_shifter i_shifter (
      .a_in  (a_in),
      .shamt (b_in[exu_pkg::shamt_w-1:0]),
      .op    (op),
      .sout  (sout)
   );

   exu_result i_result (
      .clk       (clk),
      .rst_n     (rst_n),
      .enable    (enable),
      .valid_in  (valid_in),
      .op        (op),
      .a_in      (a_in),
      .b_in      (b_in),
      .pc_in     (pc_in),
      .sout      (sout),
      .link_sel  (link_sel),
      .adr       (i_adr.result),
      .result_ff (result_ff),
      .pc_ff     (pc_ff)
   );

   exu_branch i_branch (
      .valid_in         (valid_in),
      .flush_upper_x    (flush_upper_x),
      .flush_lower_r    (flush_lower_r),
      .op               (op),
      .predict_t        (predict_t),
      .predict_nt       (predict_nt),
      .pcall            (pcall),
      .pja              (pja),
      .pret             (pret),
      .prett            (prett),
      .hist_in          (hist_in),
      .adr              (i_adr.branch),
      .link_sel         (link_sel),
      .flush_upper_out  (flush_upper_out),
      .flush_final_out  (flush_final_out),
      .flush_path_out   (flush_path_out),
      .pred_correct_out (pred_correct_out),
      .misp_out         (misp_out),
      .ataken_out       (ataken_out),
      .hist_out         (hist_out)
   );

endmodule

//--- verification/exu_checker.sv
// exu_checker: compares execute unit outputs with the expected values of each test
`timescale 1ns/100ps

module exu_checker
(
   input  logic                        clk,
   input  logic                        chk,
   input  logic [31:0]                 exp_res,
   input  logic [31:0]                 exp_pc,
   input  logic [31:0]                 exp_path,
   // flush_upper, flush_final, pred_correct, misp, ataken
   input  logic [4:0]                  exp_flg,
   input  logic [1:0]                  exp_hist,
   input  logic [exu_pkg::xlen-1:0]    result_ff,
   input  logic [exu_pkg::pc_msb:1]    pc_ff,
   input  logic                        flush_upper_out,
   input  logic                        flush_final_out,
   input  logic [exu_pkg::pc_msb:1]    flush_path_out,
   input  logic                        pred_correct_out,
   input  logic                        misp_out,
   input  logic                        ataken_out,
   input  logic [exu_pkg::hist_w-1:0]  hist_out,
   output int                          done_count,
   output int                          fail_count
);

   int          test_num;
   int          errs;
   logic        pend;
   int          pend_num;
   int          pend_errs;
   logic [31:0] pend_res;
   logic [31:0] pend_pc;

   initial
   begin
      done_count = 0;
      fail_count = 0;
      test_num   = 0;
      errs       = 0;
      pend       = 1'b0;
   end

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         errs = errs + 1;
         $display("mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // mid cycle, inputs were driven just after the rising edge
   always @(negedge clk)
   begin
      // registers of the previous test, loaded on the last edge
      if (pend)
      begin
         errs = pend_errs;
         compare("result_ff", result_ff, pend_res);
         compare("pc_ff", {pc_ff, 1'b0}, pend_pc);
         if (errs == 0)
         begin
            $display("test %0d passed", pend_num);
         end
         else
         begin
            $display("test %0d failed with %0d mismatches", pend_num, errs);
            fail_count = fail_count + 1;
         end
         done_count = done_count + 1;
         pend       = 1'b0;
      end
      // combinational branch outputs of the current test
      if (chk)
      begin
         errs = 0;
         compare("flush_upper_out", flush_upper_out, exp_flg[4]);
         compare("flush_final_out", flush_final_out, exp_flg[3]);
         compare("pred_correct_out", pred_correct_out, exp_flg[2]);
         compare("misp_out", misp_out, exp_flg[1]);
         compare("ataken_out", ataken_out, exp_flg[0]);
         compare("flush_path_out", {flush_path_out, 1'b0}, exp_path);
         compare("hist_out", hist_out, exp_hist);
         pend      = 1'b1;
         pend_errs = errs;
         pend_num  = test_num;
         pend_res  = exp_res;
         pend_pc   = exp_pc;
         test_num  = test_num + 1;
      end
   end

endmodule

//--- verification/tb_exu_alu.sv
// clock, reset, stimulus table, drive loop and timeout for the execute unit testbench
`timescale 1ns/100ps

module tb_exu_alu;

   localparam int n_tests = 33;

   // pc, offset, prett and path are byte addresses and lose bit 0 when driven
   typedef struct packed {
      logic [4:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] pc;
      logic [12:0] off;
      // valid_in, flush_lower_r, predict_t, predict_nt
      logic [3:0]  ctl;
      logic        pret;
      logic [31:0] prett;
      logic [1:0]  hist;
      logic [31:0] res;
      logic [31:0] path;
      // flush_upper, flush_final, pred_correct, misp, ataken
      logic [4:0]  flg;
      logic [1:0]  hist_x;
   } entry_t;

   logic                        clk;
   logic                        rst_n;
   logic                        enable;
   logic                        valid_in;
   logic                        flush_upper_x;
   logic                        flush_lower_r;
   logic [exu_pkg::op_w-1:0]    op;
   logic [exu_pkg::xlen-1:0]    a_in;
   logic [exu_pkg::xlen-1:0]    b_in;
   logic [exu_pkg::pc_msb:1]    pc_in;
   logic [exu_pkg::brimm_w:1]   brimm_in;
   logic                        predict_t;
   logic                        predict_nt;
   logic                        pcall;
   logic                        pja;
   logic                        pret;
   logic [exu_pkg::pc_msb:1]    prett;
   logic [exu_pkg::hist_w-1:0]  hist_in;
   logic [exu_pkg::xlen-1:0]    result_ff;
   logic [exu_pkg::pc_msb:1]    pc_ff;
   logic                        flush_upper_out;
   logic                        flush_final_out;
   logic [exu_pkg::pc_msb:1]    flush_path_out;
   logic                        pred_correct_out;
   logic                        misp_out;
   logic                        ataken_out;
   logic [exu_pkg::hist_w-1:0]  hist_out;

   logic                        chk;
   logic [31:0]                 exp_res;
   logic [31:0]                 exp_pc;
   logic [31:0]                 exp_path;
   logic [4:0]                  exp_flg;
   logic [1:0]                  exp_hist;
   int                          done_count;
   int                          fail_count;
   int                          cycles = 0;
   int                          limit;
   entry_t                      tbl [0:n_tests-1];

   exu_alu i_dut (
      .clk              (clk),
      .rst_n            (rst_n),
      .enable           (enable),
      .valid_in         (valid_in),
      .flush_upper_x    (flush_upper_x),
      .flush_lower_r    (flush_lower_r),
      .op               (op),
      .a_in             (a_in),
      .b_in             (b_in),
      .pc_in            (pc_in),
      .brimm_in         (brimm_in),
      .predict_t        (predict_t),
      .predict_nt       (predict_nt),
      .pcall            (pcall),
      .pja              (pja),
      .pret             (pret),
      .prett            (prett),
      .hist_in          (hist_in),
      .result_ff        (result_ff),
      .pc_ff            (pc_ff),
      .flush_upper_out  (flush_upper_out),
      .flush_final_out  (flush_final_out),
      .flush_path_out   (flush_path_out),
      .pred_correct_out (pred_correct_out),
      .misp_out         (misp_out),
      .ataken_out       (ataken_out),
      .hist_out         (hist_out)
   );

   exu_checker i_checker (
      .clk              (clk),
      .chk              (chk),
      .exp_res          (exp_res),
      .exp_pc           (exp_pc),
      .exp_path         (exp_path),
      .exp_flg          (exp_flg),
      .exp_hist         (exp_hist),
      .result_ff        (result_ff),
      .pc_ff            (pc_ff),
      .flush_upper_out  (flush_upper_out),
      .flush_final_out  (flush_final_out),
      .flush_path_out   (flush_path_out),
      .pred_correct_out (pred_correct_out),
      .misp_out         (misp_out),
      .ataken_out       (ataken_out),
      .hist_out         (hist_out),
      .done_count       (done_count),
      .fail_count       (fail_count)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
   end

   task automatic fill_table();
      // arithmetic and logical at pc 1000 with offset 10
      tbl[0]  = '{exu_pkg::op_add, 32'h7fff_ffff, 32'h0000_0001, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h8000_0000, 32'h1010, 5'b00000, 2'b01};
      tbl[1]  = '{exu_pkg::op_add, 32'hffff_ffff, 32'h0000_0002, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h0000_0001, 32'h1010, 5'b00000, 2'b01};
      tbl[2]  = '{exu_pkg::op_sub, 32'h0000_0005, 32'h0000_0007, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'hffff_fffe, 32'h1010, 5'b00000, 2'b01};
      tbl[3]  = '{exu_pkg::op_and, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h00f0_1200, 32'h1010, 5'b00000, 2'b01};
      tbl[4]  = '{exu_pkg::op_or, 32'hf0f0_0000, 32'h0000_1234, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'hf0f0_1234, 32'h1010, 5'b00000, 2'b01};
      tbl[5]  = '{exu_pkg::op_xor, 32'hffff_0000, 32'h0f0f_0f0f, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'hf0f0_0f0f, 32'h1010, 5'b00000, 2'b01};
      tbl[6]  = '{exu_pkg::op_lui, 32'h0000_0000, 32'h1234_5000, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h1234_5000, 32'h1010, 5'b00000, 2'b01};
      // shifts by 0, 1 and 31
      tbl[7]  = '{exu_pkg::op_sll, 32'h8000_0001, 32'h0000_0000, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h8000_0001, 32'h1010, 5'b00000, 2'b01};
      tbl[8]  = '{exu_pkg::op_sll, 32'h8000_0001, 32'h0000_0001, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h0000_0002, 32'h1010, 5'b00000, 2'b01};
      tbl[9]  = '{exu_pkg::op_sll, 32'h0000_0003, 32'h0000_001f, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h8000_0000, 32'h1010, 5'b00000, 2'b01};
      tbl[10] = '{exu_pkg::op_srl, 32'h8000_0000, 32'h0000_0001, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h4000_0000, 32'h1010, 5'b00000, 2'b01};
      tbl[11] = '{exu_pkg::op_srl, 32'h8000_0000, 32'h0000_001f, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h0000_0001, 32'h1010, 5'b00000, 2'b01};
      tbl[12] = '{exu_pkg::op_sra, 32'h8000_0000, 32'h0000_0001, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'hc000_0000, 32'h1010, 5'b00000, 2'b01};
      tbl[13] = '{exu_pkg::op_sra, 32'h8000_0000, 32'h0000_001f, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'hffff_ffff, 32'h1010, 5'b00000, 2'b01};
      tbl[14] = '{exu_pkg::op_srl, 32'h8000_0001, 32'h0000_0000, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h8000_0001, 32'h1010, 5'b00000, 2'b01};
      // only the low five bits of b count as the amount
      tbl[15] = '{exu_pkg::op_sra, 32'h8000_0001, 32'h0000_0020, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h8000_0001, 32'h1010, 5'b00000, 2'b01};
      // signed and unsigned order differ
      tbl[16] = '{exu_pkg::op_slt, 32'hffff_ffff, 32'h0000_0001, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h0000_0001, 32'h1010, 5'b00000, 2'b01};
      tbl[17] = '{exu_pkg::op_sltu, 32'hffff_ffff, 32'h0000_0001, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h0000_0000, 32'h1010, 5'b00000, 2'b01};
      tbl[18] = '{exu_pkg::op_slt, 32'h0000_0001, 32'h8000_0000, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h0000_0000, 32'h1010, 5'b00000, 2'b01};
      tbl[19] = '{exu_pkg::op_sltu, 32'h0000_0001, 32'h8000_0000, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h0000_0001, 32'h1010, 5'b00000, 2'b01};
      // conditional branches at pc 2000 with offset 40
      tbl[20] = '{exu_pkg::op_beq, 32'h0000_0005, 32'h0000_0005, 32'h2000, 13'h040, 4'b1010,
                  1'b0, 32'h0, 2'b00, 32'h0000_0000, 32'h2040, 5'b00101, 2'b10};
      tbl[21] = '{exu_pkg::op_bne, 32'h0000_0005, 32'h0000_0005, 32'h2000, 13'h040, 4'b1010,
                  1'b0, 32'h0, 2'b10, 32'h0000_0000, 32'h2040, 5'b11010, 2'b00};
      tbl[22] = '{exu_pkg::op_blt, 32'hffff_fff0, 32'h0000_0001, 32'h2000, 13'h040, 4'b1001,
                  1'b0, 32'h0, 2'b01, 32'h0000_0000, 32'h2040, 5'b11011, 2'b00};
      tbl[23] = '{exu_pkg::op_bge, 32'hffff_fff0, 32'h0000_0001, 32'h2000, 13'h040, 4'b1001,
                  1'b0, 32'h0, 2'b11, 32'h0000_0000, 32'h2040, 5'b00100, 2'b10};
      tbl[24] = '{exu_pkg::op_bltu, 32'hffff_fff0, 32'h0000_0001, 32'h2000, 13'h040, 4'b1010,
                  1'b0, 32'h0, 2'b01, 32'h0000_0000, 32'h2040, 5'b11010, 2'b01};
      // backward offset of 16 bytes
      tbl[25] = '{exu_pkg::op_bgeu, 32'hffff_fff0, 32'h0000_0001, 32'h2000, 13'h1ff0, 4'b1010,
                  1'b0, 32'h0, 2'b10, 32'h0000_0000, 32'h1ff0, 5'b00101, 2'b11};
      // jumps link to pc plus offset and target a plus b
      tbl[26] = '{exu_pkg::op_jal, 32'h0000_3000, 32'h0000_0100, 32'h2000, 13'h008, 4'b1000,
                  1'b0, 32'h0, 2'b11, 32'h0000_2008, 32'h3100, 5'b11001, 2'b11};
      tbl[27] = '{exu_pkg::op_jal, 32'h0000_4000, 32'h0000_0010, 32'h2000, 13'h004, 4'b1000,
                  1'b1, 32'h4010, 2'b00, 32'h0000_2004, 32'h4010, 5'b11001, 2'b10};
      tbl[28] = '{exu_pkg::op_jal, 32'h0000_4000, 32'h0000_0010, 32'h2000, 13'h004, 4'b1000,
                  1'b1, 32'h4020, 2'b01, 32'h0000_2004, 32'h4010, 5'b11011, 2'b00};
      // lower flush hides the upper flush and the mispredict
      tbl[29] = '{exu_pkg::op_bne, 32'h0000_0001, 32'h0000_0002, 32'h2000, 13'h040, 4'b1101,
                  1'b0, 32'h0, 2'b10, 32'h0000_0000, 32'h2040, 5'b01001, 2'b11};
      // result held while valid_in is low, pc still loads
      tbl[30] = '{exu_pkg::op_add, 32'h1111_1111, 32'h2222_2222, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h3333_3333, 32'h1010, 5'b00000, 2'b01};
      tbl[31] = '{exu_pkg::op_beq, 32'h0000_0001, 32'h0000_0001, 32'h3000, 13'h010, 4'b0110,
                  1'b0, 32'h0, 2'b00, 32'h3333_3333, 32'h3010, 5'b01001, 2'b10};
      tbl[32] = '{exu_pkg::op_add, 32'h0000_0001, 32'h0000_0001, 32'h1000, 13'h010, 4'b1000,
                  1'b0, 32'h0, 2'b00, 32'h0000_0002, 32'h1010, 5'b00000, 2'b01};
   endtask

   task automatic apply_entry(input entry_t e);
      op            = e.op;
      a_in          = e.a;
      b_in          = e.b;
      pc_in         = e.pc[31:1];
      brimm_in      = e.off[12:1];
      valid_in      = e.ctl[3];
      flush_lower_r = e.ctl[2];
      predict_t     = e.ctl[1];
      predict_nt    = e.ctl[0];
      pret          = e.pret;
      prett         = e.prett[31:1];
      hist_in       = e.hist;
      exp_res       = e.res;
      exp_pc        = e.pc;
      exp_path      = e.path;
      exp_flg       = e.flg;
      exp_hist      = e.hist_x;
      chk           = 1'b1;
   endtask

   initial
   begin
      rst_n         = 1'b0;
      enable        = 1'b0;
      valid_in      = 1'b0;
      flush_upper_x = 1'b0;
      flush_lower_r = 1'b0;
      op            = '0;
      a_in          = '0;
      b_in          = '0;
      pc_in         = '0;
      brimm_in      = '0;
      predict_t     = 1'b0;
      predict_nt    = 1'b0;
      pcall         = 1'b0;
      pja           = 1'b0;
      pret          = 1'b0;
      prett         = '0;
      hist_in       = '0;
      chk           = 1'b0;
      exp_res       = '0;
      exp_pc        = '0;
      exp_path      = '0;
      exp_flg       = '0;
      exp_hist      = '0;
      fill_table();
      limit = n_tests * 4 + 20;
      repeat (3) @(posedge clk);
      #2;
      rst_n  = 1'b1;
      enable = 1'b1;
      // one operation per cycle back to back
      for (int k = 0; k < n_tests; k++)
      begin
         @(posedge clk);
         #2;
         apply_entry(tbl[k]);
      end
      @(posedge clk);
      #2;
      chk      = 1'b0;
      valid_in = 1'b0;
      while ((done_count < n_tests) && (cycles < limit))
      begin
         @(posedge clk);
      end
      if (done_count < n_tests)
      begin
         $display("timeout: %0d of %0d tests finished after %0d cycles",
                  done_count, n_tests, cycles);
         $display("TESTS FAILED");
      end
      else
      begin
         $display("%0d tests run, %0d passed, %0d failed",
                  done_count, done_count - fail_count, fail_count);
         if (fail_count == 0)
         begin
            $display("TESTS PASSED");
         end
         else
         begin
            $display("TESTS FAILED");
         end
      end
      $finish;
   end

endmodule

//--- src.f
hdl/exu_pkg.sv
hdl/adder_if.sv
hdl/exu_adders.sv
hdl/exu_shifter.sv
hdl/exu_branch.sv
hdl/exu_result.sv
hdl/exu_alu.sv
verification/exu_checker.sv
verification/tb_exu_alu.sv
